/* hw/hive_bank_arbiter.sv */
/*
 * Round-robin arbiter in front of a hive's bank.
 * Merges the local request and the three incoming links onto one bank port
 * and returns each response to the source that issued the request.
 */

module hive_bank_arbiter import mempool_pkg::*; (
  input logic    clk_i,
  input logic    reset_i,
  tcdm_if.slave  local_i,
  tcdm_if.slave  north_i,
  tcdm_if.slave  east_i,
  tcdm_if.slave  northeast_i,
  tcdm_if.master bank_o
);

  localparam int NumSrc = 4;

  typedef logic [$clog2(NumSrc)-1:0] src_idx_t;

  bank_req_t         src_req [NumSrc];
  logic [NumSrc-1:0] src_valid;
  logic [NumSrc-1:0] src_ready;
  logic [NumSrc-1:0] src_resp_valid;
  logic [NumSrc-1:0] src_resp_ready;
  src_idx_t          rr_q;
  src_idx_t          owner_q;
  src_idx_t          gnt_idx;
  logic              gnt_valid;
  logic              bank_fire;

  // Source order: local, east, north, northeast
  assign src_req[0] = local_i.req;
  assign src_req[1] = east_i.req;
  assign src_req[2] = north_i.req;
  assign src_req[3] = northeast_i.req;

  assign src_valid = {northeast_i.req_valid, north_i.req_valid, east_i.req_valid,
                      local_i.req_valid};
  assign src_resp_ready = {northeast_i.resp_ready, north_i.resp_ready, east_i.resp_ready,
                           local_i.resp_ready};

  // First valid source at or after the pointer wins
  always_comb begin
    src_idx_t cand;
    gnt_valid = 1'b0;
    gnt_idx   = rr_q;
    for (int i = 0; i < NumSrc; i++) begin
      cand = rr_q + src_idx_t'(i);
      if (!gnt_valid && src_valid[cand]) begin
        gnt_valid = 1'b1;
        gnt_idx   = cand;
      end
    end
  end

  assign bank_o.req       = src_req[gnt_idx];
  assign bank_o.req_valid = gnt_valid;
  assign bank_fire        = gnt_valid && bank_o.req_ready;

  // Losers wait; with no request pending every source sees the bank's ready
  always_comb begin
    for (int i = 0; i < NumSrc; i++) begin
      src_ready[i]      = bank_o.req_ready && (!gnt_valid || gnt_idx == src_idx_t'(i));
      src_resp_valid[i] = bank_o.resp_valid && (owner_q == src_idx_t'(i));
    end
  end

  assign {northeast_i.req_ready, north_i.req_ready, east_i.req_ready,
          local_i.req_ready} = src_ready;
  assign {northeast_i.resp_valid, north_i.resp_valid, east_i.resp_valid,
          local_i.resp_valid} = src_resp_valid;

  // Response data is shared, only the owner sees valid
  assign local_i.resp     = bank_o.resp;
  assign east_i.resp      = bank_o.resp;
  assign north_i.resp     = bank_o.resp;
  assign northeast_i.resp = bank_o.resp;

  assign bank_o.resp_ready = src_resp_ready[owner_q];

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rr_q    <= '0;
      owner_q <= '0;
    end else if (bank_fire) begin
      rr_q    <= gnt_idx + src_idx_t'(1);
      owner_q <= gnt_idx;
    end
  end

endmodule

/* hw/hive_req_router.sv */
/*
 * Core-side request router of a hive.
 * Steers each core request to the local bank or to one of the three links
 * and returns the response of the path that was taken.
 */

module hive_req_router import mempool_pkg::*; #(
  parameter int HiveId = 0
) (
  input logic    clk_i,
  input logic    reset_i,
  tcdm_if.slave  core,
  tcdm_if.master local_o,
  tcdm_if.master north_o,
  tcdm_if.master east_o,
  tcdm_if.master northeast_o
);

  // Direction code is target hive XOR own hive: 0 local, 1 east, 2 north, 3 northeast
  localparam int NumDirs = 4;

  hive_id_t             dir;
  hive_id_t             dir_q;
  logic                 pending_q;
  bank_req_t            fwd_req;
  logic [NumDirs-1:0]   out_req_valid;
  logic [NumDirs-1:0]   out_ready;
  logic [NumDirs-1:0]   out_resp_valid;
  logic [NumDirs-1:0]   out_resp_ready;
  tcdm_resp_t           out_resp [NumDirs];
  logic                 req_fire;
  logic                 resp_fire;

  assign dir = core.req.tgt_addr[HiveIdWidth-1:0] ^ hive_id_t'(HiveId);

  // Drop the hive bits, the rest is the word inside the bank
  assign fwd_req.wdata    = core.req.wdata;
  assign fwd_req.wen      = core.req.wen;
  assign fwd_req.be       = core.req.be;
  assign fwd_req.tgt_addr = core.req.tgt_addr[TcdmAddrWidth-1:HiveIdWidth];

  // Only the selected path sees valid, and nothing while a response is owed
  always_comb begin
    out_req_valid      = '0;
    out_req_valid[dir] = core.req_valid && !pending_q;
  end

  assign local_o.req     = fwd_req;
  assign east_o.req      = fwd_req;
  assign north_o.req     = fwd_req;
  assign northeast_o.req = fwd_req;

  assign {northeast_o.req_valid, north_o.req_valid, east_o.req_valid,
          local_o.req_valid} = out_req_valid;
  assign out_ready = {northeast_o.req_ready, north_o.req_ready, east_o.req_ready,
                      local_o.req_ready};
  assign out_resp_valid = {northeast_o.resp_valid, north_o.resp_valid, east_o.resp_valid,
                           local_o.resp_valid};

  assign out_resp[0] = local_o.resp;
  assign out_resp[1] = east_o.resp;
  assign out_resp[2] = north_o.resp;
  assign out_resp[3] = northeast_o.resp;

  assign core.req_ready = !pending_q && out_ready[dir];
  assign req_fire       = core.req_valid && core.req_ready;

  // Response comes back on the path recorded at acceptance
  assign core.resp       = out_resp[dir_q];
  assign core.resp_valid = pending_q && out_resp_valid[dir_q];
  assign resp_fire       = core.resp_valid && core.resp_ready;

  always_comb begin
    out_resp_ready        = '0;
    out_resp_ready[dir_q] = pending_q && core.resp_ready;
  end

  assign {northeast_o.resp_ready, north_o.resp_ready, east_o.resp_ready,
          local_o.resp_ready} = out_resp_ready;

  // One request in flight per core
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      pending_q <= 1'b0;
      dir_q     <= '0;
    end else if (req_fire) begin
      pending_q <= 1'b1;
      dir_q     <= dir;
    end else if (resp_fire) begin
      pending_q <= 1'b0;
    end
  end

endmodule

/* hw/mempool.sv */
/*
 * Cluster top with four hives and plain per-hive core ports.
 * Links pair hive h with h^1 (east), h^2 (north) and h^3 (northeast).
 */

`include "mempool_params.svh"

module mempool import mempool_pkg::*; (
  input  logic                                   clk_i,
  input  logic                                   reset_i,
  // Core request channel
  input  logic          [`MEMPOOL_NUM_HIVES-1:0] core_req_valid_i,
  output logic          [`MEMPOOL_NUM_HIVES-1:0] core_req_ready_o,
  input  logic          [`MEMPOOL_NUM_HIVES-1:0] core_req_wen_i,
  input  strb_t         [`MEMPOOL_NUM_HIVES-1:0] core_req_be_i,
  input  tcdm_addr_t    [`MEMPOOL_NUM_HIVES-1:0] core_req_addr_i,
  input  tcdm_payload_t [`MEMPOOL_NUM_HIVES-1:0] core_req_wdata_i,
  // Core response channel
  output logic          [`MEMPOOL_NUM_HIVES-1:0] core_resp_valid_o,
  output tcdm_payload_t [`MEMPOOL_NUM_HIVES-1:0] core_resp_rdata_o,
  input  logic          [`MEMPOOL_NUM_HIVES-1:0] core_resp_ready_i
);

  localparam int NumHives = `MEMPOOL_NUM_HIVES;

  // Links indexed by the sending hive
  tcdm_if #(.req_t(bank_req_t), .resp_t(tcdm_resp_t)) north_link [NumHives] ();
  tcdm_if #(.req_t(bank_req_t), .resp_t(tcdm_resp_t)) east_link [NumHives] ();
  tcdm_if #(.req_t(bank_req_t), .resp_t(tcdm_resp_t)) northeast_link [NumHives] ();

  for (genvar h = 0; h < NumHives; h++) begin : gen_hives
    localparam int EastPeer      = h ^ 1;
    localparam int NorthPeer     = h ^ 2;
    localparam int NortheastPeer = h ^ 3;

    tcdm_if #(.req_t(tcdm_req_t), .resp_t(tcdm_resp_t)) core_if ();

    // Plain ports onto the core interface
    assign core_if.req.wdata    = core_req_wdata_i[h];
    assign core_if.req.wen      = core_req_wen_i[h];
    assign core_if.req.be       = core_req_be_i[h];
    assign core_if.req.tgt_addr = core_req_addr_i[h];
    assign core_if.req_valid    = core_req_valid_i[h];
    assign core_if.resp_ready   = core_resp_ready_i[h];
    assign core_req_ready_o[h]  = core_if.req_ready;
    assign core_resp_valid_o[h] = core_if.resp_valid;
    assign core_resp_rdata_o[h] = core_if.resp.rdata;

    mempool_hive #(
      .HiveId (h)
    ) u_hive (
      .clk_i         (clk_i),
      .reset_i       (reset_i),
      .core          (core_if),
      .north_out     (north_link[h]),
      .east_out      (east_link[h]),
      .northeast_out (northeast_link[h]),
      .north_in      (north_link[NorthPeer]),
      .east_in       (east_link[EastPeer]),
      .northeast_in  (northeast_link[NortheastPeer])
    );
  end : gen_hives

endmodule

/* hw/mempool_hive.sv */
/*
 * One hive: request router, bank arbiter and memory bank.
 * The link ports connect to the three neighbour hives at the cluster top.
 */

module mempool_hive import mempool_pkg::*; #(
  parameter int HiveId = 0
) (
  input logic    clk_i,
  input logic    reset_i,
  // Core port
  tcdm_if.slave  core,
  // Requests leaving for other hives
  tcdm_if.master north_out,
  tcdm_if.master east_out,
  tcdm_if.master northeast_out,
  // Requests arriving from other hives
  tcdm_if.slave  north_in,
  tcdm_if.slave  east_in,
  tcdm_if.slave  northeast_in
);

  // Core requests that stay in this hive
  tcdm_if #(.req_t(bank_req_t), .resp_t(tcdm_resp_t)) local_if ();

  // Arbiter to bank
  tcdm_if #(.req_t(bank_req_t), .resp_t(tcdm_resp_t)) bank_if ();

  hive_req_router #(
    .HiveId (HiveId)
  ) u_router (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .core        (core),
    .local_o     (local_if),
    .north_o     (north_out),
    .east_o      (east_out),
    .northeast_o (northeast_out)
  );

  hive_bank_arbiter u_arbiter (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .local_i     (local_if),
    .north_i     (north_in),
    .east_i      (east_in),
    .northeast_i (northeast_in),
    .bank_o      (bank_if)
  );

  tcdm_bank u_bank (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .port    (bank_if)
  );

endmodule

/* hw/mempool_pkg.sv */
/*
 * Address, data and request/response types shared by the cluster.
 * Modules take what they need through a wildcard import.
 */

`include "mempool_params.svh"

package mempool_pkg;

  // Derived widths
  localparam int unsigned HiveIdWidth   = $clog2(`MEMPOOL_NUM_HIVES);
  localparam int unsigned BankAddrWidth = $clog2(`MEMPOOL_BANK_WORDS);
  localparam int unsigned TcdmAddrWidth = HiveIdWidth + BankAddrWidth;
  localparam int unsigned StrbWidth     = `MEMPOOL_DATA_WIDTH / 8;

  typedef logic [HiveIdWidth-1:0]         hive_id_t;
  typedef logic [BankAddrWidth-1:0]       bank_addr_t;
  // Low bits pick the hive, so consecutive words interleave over the banks
  typedef logic [TcdmAddrWidth-1:0]       tcdm_addr_t;
  typedef logic [`MEMPOOL_DATA_WIDTH-1:0] tcdm_payload_t;
  typedef logic [StrbWidth-1:0]           strb_t;

  // Request as issued by a core
  typedef struct packed {
    tcdm_payload_t wdata;
    logic          wen;
    strb_t         be;
    tcdm_addr_t    tgt_addr;
  } tcdm_req_t;

  // Request after routing, addressed inside one bank
  typedef struct packed {
    tcdm_payload_t wdata;
    logic          wen;
    strb_t         be;
    bank_addr_t    tgt_addr;
  } bank_req_t;

  typedef struct packed {
    tcdm_payload_t rdata;
  } tcdm_resp_t;

endpackage

/* hw/tcdm_bank.sv */
/*
 * Single-port word memory of one hive with byte enables.
 * Every access returns one registered response, a write returns the old word.
 */

`include "mempool_params.svh"

module tcdm_bank import mempool_pkg::*; (
  input logic   clk_i,
  input logic   reset_i,
  tcdm_if.slave port
);

  tcdm_payload_t mem_q [`MEMPOOL_BANK_WORDS];
  tcdm_payload_t rdata_q;
  logic          resp_valid_q;
  logic          req_fire;

  // Accept when the output slot is free or drains this cycle
  assign port.req_ready = !resp_valid_q || port.resp_ready;
  assign req_fire       = port.req_valid && port.req_ready;

  // Storage and read data
  always_ff @(posedge clk_i) begin
    if (req_fire) begin
      rdata_q <= mem_q[port.req.tgt_addr];
      if (port.req.wen) begin
        for (int b = 0; b < StrbWidth; b++) begin
          if (port.req.be[b]) begin
            mem_q[port.req.tgt_addr][8*b +: 8] <= port.req.wdata[8*b +: 8];
          end
        end
      end
    end
  end

  // Response flag, held until the master takes it
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      resp_valid_q <= 1'b0;
    end else if (req_fire) begin
      resp_valid_q <= 1'b1;
    end else if (port.resp_ready) begin
      resp_valid_q <= 1'b0;
    end
  end

  assign port.resp.rdata = rdata_q;
  assign port.resp_valid = resp_valid_q;

endmodule

/* hw/tcdm_if.sv */
/*
 * Valid/ready request and response channel between TCDM blocks.
 * Instantiate with the request and response payload types in use.
 */

interface tcdm_if #(
  parameter type req_t  = logic,
  parameter type resp_t = logic
) ();

  // Request channel
  req_t  req;
  logic  req_valid;
  logic  req_ready;

  // Response channel
  resp_t resp;
  logic  resp_valid;
  logic  resp_ready;

  modport master (
    output req, req_valid, resp_ready,
    input  req_ready, resp, resp_valid
  );

  modport slave (
    input  req, req_valid, resp_ready,
    output req_ready, resp, resp_valid
  );

endinterface

/* include/mempool_params.svh */
/*
 * Cluster-wide size constants of the reduced MemPool cluster.
 * Include wherever a size is needed. The types live in mempool_pkg.
 */

`ifndef MEMPOOL_PARAMS_SVH
`define MEMPOOL_PARAMS_SVH

// Hive count, the XOR link wiring only works for four
`define MEMPOOL_NUM_HIVES 4

// Word width of the cores and banks
`define MEMPOOL_DATA_WIDTH 32

// Words held by one bank
`define MEMPOOL_BANK_WORDS 64

`endif

/* run.sh */
#!/bin/sh
# Build the cluster testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal -f tb.f --top-module tb_mempool \
  --Mdir obj_dir -o tb_mempool_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/tb_mempool_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "TEST PASS"; then
  exit 0
fi
exit 1

/* sim/mempool_assert.sv */
/*
 * Handshake assertions for one hive, bound into every mempool_hive.
 * Covers core response timing, request and response stability and router steering.
 */

module mempool_assert import mempool_pkg::*; #(
  parameter int HiveId = 0
) (
  input logic       clk_i,
  input logic       reset_i,
  input logic       core_req_valid_i,
  input logic       core_req_ready_i,
  input tcdm_req_t  core_req_i,
  input logic       core_resp_valid_i,
  input logic       core_resp_ready_i,
  input tcdm_resp_t core_resp_i,
  input logic       local_valid_i,
  input logic       north_valid_i,
  input logic       east_valid_i,
  input logic       northeast_valid_i
);
  timeunit 1ns;
  timeprecision 100ps;

  hive_id_t   tgt_hive;
  logic [3:0] route_valid;
  logic [3:0] route_exp;

  assign tgt_hive    = core_req_i.tgt_addr[HiveIdWidth-1:0];
  assign route_valid = {northeast_valid_i, north_valid_i, east_valid_i, local_valid_i};
  // Northeast, north and east reach hive id XOR 3, 2 and 1
  assign route_exp   = {tgt_hive == hive_id_t'(HiveId ^ 3), tgt_hive == hive_id_t'(HiveId ^ 2),
                        tgt_hive == hive_id_t'(HiveId ^ 1), tgt_hive == hive_id_t'(HiveId)};

  // Response one cycle after the core request transfers
  resp_follows_req: assert property (@(posedge clk_i) disable iff (reset_i)
    core_req_valid_i && core_req_ready_i |=> core_resp_valid_i)
    else $error("core response missing one cycle after an accepted request");

  // Held-off request keeps its payload
  req_held_stable: assert property (@(posedge clk_i) disable iff (reset_i)
    core_req_valid_i && !core_req_ready_i |=> core_req_valid_i && $stable(core_req_i))
    else $error("core request changed or dropped before it was accepted");

  // Held response keeps its data
  resp_held_stable: assert property (@(posedge clk_i) disable iff (reset_i)
    core_resp_valid_i && !core_resp_ready_i |=> core_resp_valid_i && $stable(core_resp_i))
    else $error("core response changed or dropped before it was taken");

  // Router drives only the one path that leads to the target hive
  route_to_target: assert property (@(posedge clk_i) disable iff (reset_i)
    route_valid != '0 |-> core_req_valid_i && route_valid == route_exp)
    else $error("router output valid does not match the target hive");

endmodule

/* sim/tb_mempool.sv */
/*
 * Directed testbench for the four-hive cluster.
 * Drives the plain core ports, predicts read data with a shadow memory
 * and checks handshake timing. Run through tb.f with tb_mempool as top.
 */

`include "mempool_params.svh"

module tb_mempool import mempool_pkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int NumHives     = `MEMPOOL_NUM_HIVES;
  localparam int BankWords    = `MEMPOOL_BANK_WORDS;
  localparam int AddrSpace    = 1 << TcdmAddrWidth;
  localparam int ClkPeriod    = 100;
  localparam int DriveDelay   = 10;
  localparam int ResetCycles  = 16;
  localparam int OpLimit      = 32;
  localparam int RemoteRounds = 4;
  localparam int ByteRounds   = 8;
  localparam int HoldCycles   = 5;
  // Three cycles per access round leaves room for grant delays
  localparam int TotalCycles  = ResetCycles + 2 * BankWords * 3
                                + (NumHives - 1) * RemoteRounds * 2 * 3 + ByteRounds * 2 * 3
                                + NumHives * 2 * (NumHives + 3) + 2 * (HoldCycles + 3);
  localparam int WatchdogNs   = 2 * TotalCycles * ClkPeriod;
  localparam logic [31:0] LfsrSeed = 32'h5a06644c;
  localparam logic [31:0] LfsrTaps = 32'h80200003;

  logic                           clk_i;
  logic                           reset_i;
  logic          [NumHives-1:0]   core_req_valid_i;
  logic          [NumHives-1:0]   core_req_ready_o;
  logic          [NumHives-1:0]   core_req_wen_i;
  strb_t         [NumHives-1:0]   core_req_be_i;
  tcdm_addr_t    [NumHives-1:0]   core_req_addr_i;
  tcdm_payload_t [NumHives-1:0]   core_req_wdata_i;
  logic          [NumHives-1:0]   core_resp_valid_o;
  tcdm_payload_t [NumHives-1:0]   core_resp_rdata_o;
  logic          [NumHives-1:0]   core_resp_ready_i;

  // Shadow of the cluster memory indexed by cluster word address
  tcdm_payload_t shadow_mem [AddrSpace];
  logic          known [AddrSpace];

  // Current access of each core
  logic          op_wen [NumHives];
  strb_t         op_be [NumHives];
  tcdm_addr_t    op_addr [NumHives];
  tcdm_payload_t op_wdata [NumHives];
  tcdm_payload_t op_exp [NumHives];
  logic          op_check [NumHives];

  logic [31:0] lfsr_q;
  int          errors;
  int          checks;

  mempool u_mempool (
    .clk_i             (clk_i),
    .reset_i           (reset_i),
    .core_req_valid_i  (core_req_valid_i),
    .core_req_ready_o  (core_req_ready_o),
    .core_req_wen_i    (core_req_wen_i),
    .core_req_be_i     (core_req_be_i),
    .core_req_addr_i   (core_req_addr_i),
    .core_req_wdata_i  (core_req_wdata_i),
    .core_resp_valid_o (core_resp_valid_o),
    .core_resp_rdata_o (core_resp_rdata_o),
    .core_resp_ready_i (core_resp_ready_i)
  );

  bind mempool_hive mempool_assert #(
    .HiveId (HiveId)
  ) u_assert (
    .clk_i             (clk_i),
    .reset_i           (reset_i),
    .core_req_valid_i  (core.req_valid),
    .core_req_ready_i  (core.req_ready),
    .core_req_i        (core.req),
    .core_resp_valid_i (core.resp_valid),
    .core_resp_ready_i (core.resp_ready),
    .core_resp_i       (core.resp),
    .local_valid_i     (local_if.req_valid),
    .north_valid_i     (north_out.req_valid),
    .east_valid_i      (east_out.req_valid),
    .northeast_valid_i (northeast_out.req_valid)
  );

  initial begin
    clk_i = 1'b0;
    forever #(ClkPeriod / 2) clk_i = ~clk_i;
  end

  initial begin
    #(WatchdogNs);
    $display("Timeout: the tests did not finish within %0d ns", WatchdogNs);
    $display("TEST FAIL");
    $finish;
  end

  // Galois LFSR stepped once per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r = {r[30:0], lfsr_q[0]};
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ LfsrTaps) : (lfsr_q >> 1);
    end
    return r;
  endfunction

  function automatic tcdm_payload_t merge_bytes(input tcdm_payload_t old_word,
                                                input tcdm_payload_t new_word, input strb_t be);
    tcdm_payload_t w;
    w = old_word;
    for (int b = 0; b < StrbWidth; b++) begin
      if (be[b]) begin
        w[8*b +: 8] = new_word[8*b +: 8];
      end
    end
    return w;
  endfunction

  // Word index above the hive bits
  function automatic tcdm_addr_t cluster_addr(input int hive, input int word);
    return {bank_addr_t'(word), hive_id_t'(hive)};
  endfunction

  task automatic check_data(input tcdm_payload_t got, input tcdm_payload_t exp,
                            input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR %0t ns: %s, got %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR %0t ns: %s, got %b, expected %b", $time, what, got, exp);
    end
  endtask

  // Load one core's access and predict its response from the shadow memory
  task automatic start_op(input int c, input logic wen, input strb_t be, input tcdm_addr_t addr,
                          input tcdm_payload_t wdata);
    op_wen[c]   = wen;
    op_be[c]    = be;
    op_addr[c]  = addr;
    op_wdata[c] = wdata;
    op_exp[c]   = shadow_mem[addr];
    op_check[c] = known[addr];
    if (wen) begin
      shadow_mem[addr] = merge_bytes(shadow_mem[addr], wdata, be);
      known[addr]      = known[addr] || (be == '1);
    end
  endtask

  // Runs the loaded accesses of the masked cores
  // Entered and left at edge plus DriveDelay
  task automatic run_ops(input logic [NumHives-1:0] mask, input int hold,
                         output int last_accept);
    logic [NumHives-1:0] req_pend;
    logic [NumHives-1:0] resp_pend;
    int                  acc_cyc [NumHives];
    int                  cyc;
    req_pend    = mask;
    resp_pend   = '0;
    last_accept = 0;
    cyc         = 0;
    for (int c = 0; c < NumHives; c++) begin
      acc_cyc[c] = 0;
    end
    while ((req_pend | resp_pend) != '0 && cyc < OpLimit) begin
      for (int c = 0; c < NumHives; c++) begin
        core_req_valid_i[c]  = req_pend[c];
        core_req_wen_i[c]    = op_wen[c];
        core_req_be_i[c]     = op_be[c];
        core_req_addr_i[c]   = op_addr[c];
        core_req_wdata_i[c]  = op_wdata[c];
        core_resp_ready_i[c] = resp_pend[c] && (cyc > acc_cyc[c] + hold);
      end
      // Sample mid-cycle once outputs have settled
      #(ClkPeriod / 2);
      for (int c = 0; c < NumHives; c++) begin
        if (resp_pend[c]) begin
          check_bit(core_req_ready_o[c], 1'b0, "req_ready low while a response is owed");
          check_bit(core_resp_valid_o[c], 1'b1, "response valid from one cycle after accept");
          if (op_check[c]) begin
            check_data(core_resp_rdata_o[c], op_exp[c], "response data");
          end
          if (core_resp_ready_i[c]) begin
            resp_pend[c] = 1'b0;
          end
        end else begin
          check_bit(core_resp_valid_o[c], 1'b0, "no response before an accepted request");
          if (req_pend[c] && core_req_ready_o[c]) begin
            req_pend[c]  = 1'b0;
            resp_pend[c] = 1'b1;
            acc_cyc[c]   = cyc;
            last_accept  = cyc;
          end
        end
      end
      @(posedge clk_i);
      #DriveDelay;
      cyc++;
    end
    core_req_valid_i  = '0;
    core_resp_ready_i = '0;
    if ((req_pend | resp_pend) != '0) begin
      errors++;
      $display("Cores %b did not finish their accesses within %0d cycles",
               req_pend | resp_pend, OpLimit);
    end
  endtask

  task automatic check_idle();
    for (int c = 0; c < NumHives; c++) begin
      check_bit(core_resp_valid_o[c], 1'b0, "resp_valid low in reset state");
      check_bit(core_req_ready_o[c], 1'b1, "req_ready high in reset state");
    end
  endtask

  task automatic test_reset();
    for (int i = 0; i < ResetCycles; i++) begin
      @(posedge clk_i);
      #DriveDelay;
      if (i == ResetCycles - 1) begin
        reset_i = 1'b0;
      end
      #(ClkPeriod / 2);
      if (i > 0) begin
        check_idle();
      end
    end
    @(posedge clk_i);
    #DriveDelay;
  endtask

  // Fills every bank from its own core, then reads it all back
  task automatic test_local();
    int last;
    for (int w = 0; w < BankWords; w++) begin
      for (int c = 0; c < NumHives; c++) begin
        start_op(c, 1'b1, '1, cluster_addr(c, w), rand_bits(32));
      end
      run_ops('1, 0, last);
    end
    for (int w = 0; w < BankWords; w++) begin
      for (int c = 0; c < NumHives; c++) begin
        start_op(c, 1'b0, '1, cluster_addr(c, w), '0);
      end
      run_ops('1, 0, last);
    end
  endtask

  // Direction code d sends core c to hive c^d
  task automatic test_remote();
    tcdm_addr_t addr [NumHives];
    int         last;
    for (int d = 1; d < NumHives; d++) begin
      for (int r = 0; r < RemoteRounds; r++) begin
        for (int c = 0; c < NumHives; c++) begin
          addr[c] = cluster_addr(c ^ d, int'(rand_bits(BankAddrWidth)));
          start_op(c, 1'b1, '1, addr[c], rand_bits(32));
        end
        run_ops('1, 0, last);
        // Neighbour core reads back
        for (int c = 0; c < NumHives; c++) begin
          start_op((c + 1) % NumHives, 1'b0, '1, addr[c], '0);
        end
        run_ops('1, 0, last);
      end
    end
  endtask

  task automatic test_byte_enables();
    tcdm_addr_t addr [NumHives];
    int         last;
    for (int r = 0; r < ByteRounds; r++) begin
      for (int c = 0; c < NumHives; c++) begin
        addr[c] = cluster_addr(c, int'(rand_bits(BankAddrWidth)));
        start_op(c, 1'b1, strb_t'(rand_bits(StrbWidth)), addr[c], rand_bits(32));
      end
      run_ops('1, 0, last);
      for (int c = 0; c < NumHives; c++) begin
        start_op(c, 1'b0, '1, addr[c], '0);
      end
      run_ops('1, 0, last);
    end
  endtask

  // All cores hit distinct words of one bank in the same cycle
  task automatic test_contention();
    tcdm_addr_t addr [NumHives];
    int         base;
    int         last;
    for (int t = 0; t < NumHives; t++) begin
      base = int'(rand_bits(BankAddrWidth));
      for (int c = 0; c < NumHives; c++) begin
        addr[c] = cluster_addr(t, base + c);
        start_op(c, 1'b1, '1, addr[c], rand_bits(32));
      end
      run_ops('1, 0, last);
      check_bit(logic'(last < NumHives), 1'b1, "writes granted within four cycles");
      for (int c = 0; c < NumHives; c++) begin
        start_op(c, 1'b0, '1, addr[c], '0);
      end
      run_ops('1, 0, last);
      check_bit(logic'(last < NumHives), 1'b1, "reads granted within four cycles");
    end
  endtask

  task automatic test_backpressure();
    int last;
    for (int c = 0; c < NumHives; c++) begin
      start_op(c, 1'b0, '1, cluster_addr(c, int'(rand_bits(BankAddrWidth))), '0);
    end
    run_ops('1, HoldCycles, last);
    // Remote writes held off the same way
    for (int c = 0; c < NumHives; c++) begin
      start_op(c, 1'b1, '1, cluster_addr(c ^ 3, int'(rand_bits(BankAddrWidth))),
               rand_bits(32));
    end
    run_ops('1, HoldCycles, last);
  endtask

  initial begin
    errors            = 0;
    checks            = 0;
    lfsr_q            = LfsrSeed;
    reset_i           = 1'b1;
    core_req_valid_i  = '0;
    core_req_wen_i    = '0;
    core_req_be_i     = '0;
    core_req_addr_i   = '0;
    core_req_wdata_i  = '0;
    core_resp_ready_i = '0;
    for (int a = 0; a < AddrSpace; a++) begin
      shadow_mem[a] = '0;
      known[a]      = 1'b0;
    end
    for (int c = 0; c < NumHives; c++) begin
      start_op(c, 1'b0, '0, '0, '0);
    end
    test_reset();
    test_local();
    test_remote();
    test_byte_enables();
    test_contention();
    test_backpressure();
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

/* tb.f */
+incdir+include
hw/mempool_pkg.sv
hw/tcdm_if.sv
hw/tcdm_bank.sv
hw/hive_req_router.sv
hw/hive_bank_arbiter.sv
hw/mempool_hive.sv
hw/mempool.sv
sim/mempool_assert.sv
sim/tb_mempool.sv
